//--- logic/block_mmu_top.sv
// ============================================================
// Blocked matrix multiply top
// Memory, bus arbiter, two tile fetchers and the multiplier
// ============================================================
`timescale 1ns/1ps

module block_mmu_top import matrix_pkg::*; #(
    parameter int MATRIX_SIZE = matrix_pkg::MATRIX_SIZE,
    parameter int BLOCK_SIZE  = matrix_pkg::BLOCK_SIZE,
    parameter int DATA_WIDTH  = matrix_pkg::DATA_WIDTH
) (
    input  logic                          clk,
    input  logic                          rst_n,
    // Host write
    input  logic                          host_we,
    input  logic [ADDR_W-1:0]             host_addr,
    input  logic [DATA_WIDTH-1:0]         host_wdata,
    // Command
    input  logic                          cmd_req,
    input  logic [BLK_IDX_W-1:0]          cmd_row_blk,
    input  logic [BLK_IDX_W-1:0]          cmd_col_blk,
    input  logic [BLK_IDX_W-1:0]          cmd_k_blk,
    output logic                          cmd_ack,
    // Result stream
    output logic                          res_valid,
    output logic [ACC_WIDTH-1:0]          res_data,
    output logic [$clog2(TILE_ELEMS)-1:0] res_index,
    input  logic                          res_ready
);

    logic [ADDR_W-1:0]             rd_addr;
    logic [DATA_WIDTH-1:0]         rd_data;
    logic                          start;
    logic [BLK_IDX_W-1:0]          a_row_blk, a_col_blk;
    logic [BLK_IDX_W-1:0]          b_row_blk, b_col_blk;
    logic                          a_done, b_done;
    logic [TILE_ELEMS*DATA_WIDTH-1:0] a_tile, b_tile;

    mem_bus_if bus_a ();
    mem_bus_if bus_b ();

    matrix_mem #(.DATA_WIDTH(DATA_WIDTH)) matrix_mem_inst (
        .clk        (clk),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    mem_arbiter #(.DATA_WIDTH(DATA_WIDTH)) mem_arbiter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_a   (bus_a.arbiter),
        .req_b   (bus_b.arbiter),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ============================================================
    // Tile fetchers, A and B peers on the bus
    // ============================================================
    tile_fetcher #(
        .BASE_ADDR   (A_BASE),
        .MATRIX_SIZE (MATRIX_SIZE),
        .BLOCK_SIZE  (BLOCK_SIZE),
        .DATA_WIDTH  (DATA_WIDTH)
    ) fetch_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .blk_row   (a_row_blk),
        .blk_col   (a_col_blk),
        .bus       (bus_a.requester),
        .tile_flat (a_tile),
        .tile_done (a_done)
    );

    tile_fetcher #(
        .BASE_ADDR   (B_BASE),
        .MATRIX_SIZE (MATRIX_SIZE),
        .BLOCK_SIZE  (BLOCK_SIZE),
        .DATA_WIDTH  (DATA_WIDTH)
    ) fetch_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .blk_row   (b_row_blk),
        .blk_col   (b_col_blk),
        .bus       (bus_b.requester),
        .tile_flat (b_tile),
        .tile_done (b_done)
    );

    tile_multiplier #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .DATA_WIDTH (DATA_WIDTH)
    ) tile_multiplier_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_req     (cmd_req),
        .cmd_row_blk (cmd_row_blk),
        .cmd_col_blk (cmd_col_blk),
        .cmd_k_blk   (cmd_k_blk),
        .cmd_ack     (cmd_ack),
        .start       (start),
        .a_row_blk   (a_row_blk),
        .a_col_blk   (a_col_blk),
        .b_row_blk   (b_row_blk),
        .b_col_blk   (b_col_blk),
        .a_done      (a_done),
        .b_done      (b_done),
        .a_tile      (a_tile),
        .b_tile      (b_tile),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_index   (res_index),
        .res_ready   (res_ready)
    );

endmodule

//--- logic/matrix_mem.sv
// ============================================================
// Matrix memory
// Holds A and B; host write port, one registered read port
// ============================================================
`timescale 1ns/1ps

module matrix_mem import matrix_pkg::*; #(
    parameter int DATA_WIDTH = matrix_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  host_we,
    input  logic [ADDR_W-1:0]     host_addr,
    input  logic [DATA_WIDTH-1:0] host_wdata,
    input  logic [ADDR_W-1:0]     rd_addr,
    output logic [DATA_WIDTH-1:0] rd_data
);

    // Contents only meaningful once the host has loaded them
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // ============================================================
    // Host write
    // ============================================================
    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    // ============================================================
    // Registered read
    // ============================================================
    // Data appears the cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- logic/matrix_pkg.sv
// ============================================================
// Matrix package
// Size constants, derived widths and memory layout shared by
// the blocked matrix multiply subsystem
// ============================================================
package matrix_pkg;

    // ============================================================
    // Base sizes
    // ============================================================
    localparam int MATRIX_SIZE = 8;     // Rows and columns of A and B
    localparam int BLOCK_SIZE  = 4;     // Rows and columns of one tile
    localparam int DATA_WIDTH  = 8;     // Stored element width

    // ============================================================
    // Derived widths
    // ============================================================
    // Product of two elements plus growth over BLOCK_SIZE terms
    localparam int ACC_WIDTH  = 2 * DATA_WIDTH + $clog2(BLOCK_SIZE);

    localparam int BLK_IDX_W  = $clog2(MATRIX_SIZE / BLOCK_SIZE);
    localparam int TILE_ELEMS = BLOCK_SIZE * BLOCK_SIZE;

    // ============================================================
    // Memory layout
    // ============================================================
    // A then B, both row-major, one element per word
    localparam int MEM_DEPTH = 2 * MATRIX_SIZE * MATRIX_SIZE;
    localparam int ADDR_W    = $clog2(MEM_DEPTH);
    localparam int A_BASE    = 0;
    localparam int B_BASE    = MATRIX_SIZE * MATRIX_SIZE;

endpackage

//--- logic/mem_arbiter.sv
// ============================================================
// Read bus arbiter
// Round-robin between two tile fetchers, grant held per tile,
// read data routed back to the port that issued the address
// ============================================================
`timescale 1ns/1ps

module mem_arbiter import matrix_pkg::*; #(
    parameter int DATA_WIDTH = matrix_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    mem_bus_if.arbiter            req_a,
    mem_bus_if.arbiter            req_b,
    output logic [ADDR_W-1:0]     rd_addr,
    input  logic [DATA_WIDTH-1:0] rd_data
);

    logic gnt_a_q, gnt_b_q;
    logic gnt_a_d, gnt_b_d;
    logic last_b;               // Port B served most recently
    logic pend_a, pend_b;       // Read in flight, per port

    // ============================================================
    // Next grant
    // ============================================================
    always_comb begin
        gnt_a_d = 1'b0;
        gnt_b_d = 1'b0;
        if (gnt_a_q && req_a.req) begin
            gnt_a_d = 1'b1;                 // Owner keeps the bus
        end else if (gnt_b_q && req_b.req) begin
            gnt_b_d = 1'b1;
        end else if (req_a.req && req_b.req) begin
            // Both waiting, favour the one not served last
            gnt_a_d = last_b;
            gnt_b_d = !last_b;
        end else begin
            gnt_a_d = req_a.req;
            gnt_b_d = req_b.req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt_a_q <= 1'b0;
            gnt_b_q <= 1'b0;
            last_b  <= 1'b1;
            pend_a  <= 1'b0;
            pend_b  <= 1'b0;
        end else begin
            gnt_a_q <= gnt_a_d;
            gnt_b_q <= gnt_b_d;
            if (gnt_a_d || gnt_b_d) begin
                last_b <= gnt_b_d;
            end
            pend_a <= gnt_a_q && req_a.req;  // Address issued this cycle
            pend_b <= gnt_b_q && req_b.req;
        end
    end

    // Granted address goes to the memory
    assign rd_addr = gnt_b_q ? req_b.addr : req_a.addr;

    assign req_a.gnt    = gnt_a_q;
    assign req_b.gnt    = gnt_b_q;
    assign req_a.rdata  = rd_data;
    assign req_b.rdata  = rd_data;
    assign req_a.rvalid = pend_a;
    assign req_b.rvalid = pend_b;

endmodule

//--- logic/mem_bus_if.sv
// ============================================================
// Shared read bus port
// One requester's connection to the round-robin arbiter
// ============================================================
`timescale 1ns/1ps

interface mem_bus_if import matrix_pkg::*;;

    logic                  req;     // Held for a whole tile
    logic [ADDR_W-1:0]     addr;
    logic                  gnt;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  rvalid;  // One cycle after the address

    // Tile fetcher side
    modport requester (
        output req,
        output addr,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    // Arbiter side
    modport arbiter (
        input  req,
        input  addr,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

//--- logic/tile_fetcher.sv
// ============================================================
// Tile fetcher
// Reads one BLOCK_SIZE x BLOCK_SIZE tile over the shared bus
// and gathers it into a flat tile register
// ============================================================
`timescale 1ns/1ps

module tile_fetcher import matrix_pkg::*; #(
    parameter int BASE_ADDR   = 0,
    parameter int MATRIX_SIZE = matrix_pkg::MATRIX_SIZE,
    parameter int BLOCK_SIZE  = matrix_pkg::BLOCK_SIZE,
    parameter int DATA_WIDTH  = matrix_pkg::DATA_WIDTH
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  logic [BLK_IDX_W-1:0]             blk_row,
    input  logic [BLK_IDX_W-1:0]             blk_col,
    mem_bus_if.requester                     bus,
    output logic [TILE_ELEMS*DATA_WIDTH-1:0] tile_flat,
    output logic                             tile_done
);

    localparam int CNT_W = $clog2(BLOCK_SIZE);
    localparam int IDX_W = $clog2(TILE_ELEMS);

    logic                 req_q;
    logic [BLK_IDX_W-1:0] row_q, col_q;     // Latched block indices
    logic [CNT_W-1:0]     r, c;             // Issue position in tile
    logic [IDX_W-1:0]     wr_idx;           // Next returned element
    logic                 issue;
    logic                 last_issue;

    assign issue      = req_q && bus.gnt;
    assign last_issue = (r == CNT_W'(BLOCK_SIZE - 1)) && (c == CNT_W'(BLOCK_SIZE - 1));

    // Row-major element address inside the selected matrix
    assign bus.req  = req_q;
    assign bus.addr = ADDR_W'(BASE_ADDR + (row_q * BLOCK_SIZE + r) * MATRIX_SIZE
                              + col_q * BLOCK_SIZE + c);

    // ============================================================
    // Address walk and return counting
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            row_q     <= '0;
            col_q     <= '0;
            r         <= '0;
            c         <= '0;
            wr_idx    <= '0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            if (start && !req_q) begin
                req_q  <= 1'b1;
                row_q  <= blk_row;
                col_q  <= blk_col;
                r      <= '0;
                c      <= '0;
                wr_idx <= '0;
            end else if (issue) begin
                c <= c + 1'b1;                  // Wraps to the next row
                if (c == CNT_W'(BLOCK_SIZE - 1)) begin
                    r <= r + 1'b1;
                end
                if (last_issue) begin
                    req_q <= 1'b0;              // Release the bus
                end
            end
            if (bus.rvalid) begin
                wr_idx <= wr_idx + 1'b1;
                tile_done <= (wr_idx == IDX_W'(TILE_ELEMS - 1));
            end
        end
    end

    // Returns arrive in issue order
    always_ff @(posedge clk) begin
        if (bus.rvalid) begin
            tile_flat[wr_idx*DATA_WIDTH +: DATA_WIDTH] <= bus.rdata;
        end
    end

endmodule

//--- logic/tile_multiplier.sv
// ============================================================
// Tile multiplier
// Command handshake, fetch control, one MAC per cycle and
// result streaming under back-pressure
// ============================================================
`timescale 1ns/1ps

module tile_multiplier import matrix_pkg::*; #(
    parameter int BLOCK_SIZE = matrix_pkg::BLOCK_SIZE,
    parameter int DATA_WIDTH = matrix_pkg::DATA_WIDTH
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             cmd_req,
    input  logic [BLK_IDX_W-1:0]             cmd_row_blk,
    input  logic [BLK_IDX_W-1:0]             cmd_col_blk,
    input  logic [BLK_IDX_W-1:0]             cmd_k_blk,
    output logic                             cmd_ack,
    output logic                             start,
    output logic [BLK_IDX_W-1:0]             a_row_blk,
    output logic [BLK_IDX_W-1:0]             a_col_blk,
    output logic [BLK_IDX_W-1:0]             b_row_blk,
    output logic [BLK_IDX_W-1:0]             b_col_blk,
    input  logic                             a_done,
    input  logic                             b_done,
    input  logic [TILE_ELEMS*DATA_WIDTH-1:0] a_tile,
    input  logic [TILE_ELEMS*DATA_WIDTH-1:0] b_tile,
    output logic                             res_valid,
    output logic [ACC_WIDTH-1:0]             res_data,
    output logic [$clog2(TILE_ELEMS)-1:0]    res_index,
    input  logic                             res_ready
);

    localparam int CNT_W = $clog2(BLOCK_SIZE);
    localparam int IDX_W = $clog2(TILE_ELEMS);

    typedef enum logic [2:0] {ST_IDLE, ST_FETCH, ST_COMPUTE, ST_STREAM, ST_ACK} state_t;

    state_t               state;
    logic [BLK_IDX_W-1:0] row_q, col_q, k_q;    // Command indices
    logic                 a_got, b_got;
    logic [CNT_W-1:0]     i, j, k;
    logic [IDX_W-1:0]     out_idx;
    logic [ACC_WIDTH-1:0] res_tile [TILE_ELEMS];
    logic [DATA_WIDTH-1:0] a_el, b_el;
    logic [ACC_WIDTH-1:0] prod;

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCK_SIZE - 1);

    // A(i,k) and B(k,j) from the flat tiles
    assign a_el = a_tile[(i*BLOCK_SIZE + k)*DATA_WIDTH +: DATA_WIDTH];
    assign b_el = b_tile[(k*BLOCK_SIZE + j)*DATA_WIDTH +: DATA_WIDTH];
    assign prod = ACC_WIDTH'(a_el) * ACC_WIDTH'(b_el);

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            start <= 1'b0;
            row_q <= '0;
            col_q <= '0;
            k_q   <= '0;
            a_got <= 1'b0;
            b_got <= 1'b0;
            i <= '0;
            j <= '0;
            k <= '0;
            out_idx <= '0;
        end else begin
            start <= 1'b0;
            case (state)
                ST_IDLE: if (cmd_req) begin
                    row_q <= cmd_row_blk;
                    col_q <= cmd_col_blk;
                    k_q   <= cmd_k_blk;
                    a_got <= 1'b0;
                    b_got <= 1'b0;
                    start <= 1'b1;                  // Both fetchers at once
                    state <= ST_FETCH;
                end
                ST_FETCH: begin
                    a_got <= a_got || a_done;
                    b_got <= b_got || b_done;
                    if ((a_got || a_done) && (b_got || b_done)) begin
                        i <= '0;
                        j <= '0;
                        k <= '0;
                        state <= ST_COMPUTE;
                    end
                end
                ST_COMPUTE: begin
                    k <= k + 1'b1;
                    if (k == CNT_LAST) begin
                        j <= j + 1'b1;
                        if (j == CNT_LAST) begin
                            i <= i + 1'b1;
                            if (i == CNT_LAST) begin
                                out_idx <= '0;
                                state   <= ST_STREAM;
                            end
                        end
                    end
                end
                ST_STREAM: if (res_ready) begin
                    out_idx <= out_idx + 1'b1;
                    if (out_idx == IDX_W'(TILE_ELEMS - 1)) state <= ST_ACK;
                end
                ST_ACK: if (!cmd_req) state <= ST_IDLE;  // Four-phase release
                default: state <= ST_IDLE;
            endcase
        end
    end

    // MAC into the result tile, first term overwrites
    always_ff @(posedge clk) begin
        if (state == ST_COMPUTE) begin
            res_tile[i*BLOCK_SIZE + j] <= (k == '0 ? '0 : res_tile[i*BLOCK_SIZE + j]) + prod;
        end
    end

    assign a_row_blk = row_q;
    assign a_col_blk = k_q;
    assign b_row_blk = k_q;
    assign b_col_blk = col_q;

    assign res_valid = (state == ST_STREAM);
    assign res_data  = res_tile[out_idx];
    assign res_index = out_idx;
    assign cmd_ack   = (state == ST_ACK);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the blocked matrix multiply testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_block_mmu -o sim_block_mmu

# Status comes from the log, the run itself always exits normally
./obj_dir/sim_block_mmu > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

//--- verification/block_mmu_checker.sv
// ============================================================
// Blocked matrix multiply checker
// Shadows host writes, predicts each result element and
// watches the result stream and command handshake
// ============================================================
`timescale 1ns/1ps

module block_mmu_checker import matrix_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          host_we,
    input  logic [ADDR_W-1:0]             host_addr,
    input  logic [DATA_WIDTH-1:0]         host_wdata,
    input  logic                          cmd_req,
    input  logic [BLK_IDX_W-1:0]          cmd_row_blk,
    input  logic [BLK_IDX_W-1:0]          cmd_col_blk,
    input  logic [BLK_IDX_W-1:0]          cmd_k_blk,
    input  logic                          cmd_ack,
    input  logic                          res_valid,
    input  logic [ACC_WIDTH-1:0]          res_data,
    input  logic [$clog2(TILE_ELEMS)-1:0] res_index,
    input  logic                          res_ready,
    output int                            err_count,
    output int                            elem_count
);

    localparam int IDX_W = $clog2(TILE_ELEMS);

    logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];  // Copy of A then B
    int                    exp_idx;
    logic                  stalled;
    logic [ACC_WIDTH-1:0]  held_data;
    logic [IDX_W-1:0]      held_index;
    logic                  ack_q, req_q;
    logic [ACC_WIDTH-1:0]  expected;

    // ============================================================
    // Reference model
    // ============================================================
    // Element (i, j) of A(rb, kb) times B(kb, cb), row-major index
    function automatic logic [ACC_WIDTH-1:0] expected_elem(int rb, int cb, int kb, int idx);
        int i;
        int j;
        int k;
        int a_addr;
        int b_addr;
        logic [ACC_WIDTH-1:0] sum;
        i   = idx / BLOCK_SIZE;
        j   = idx % BLOCK_SIZE;
        sum = '0;
        for (k = 0; k < BLOCK_SIZE; k++) begin
            a_addr = A_BASE + (rb * BLOCK_SIZE + i) * MATRIX_SIZE + kb * BLOCK_SIZE + k;
            b_addr = B_BASE + (kb * BLOCK_SIZE + k) * MATRIX_SIZE + cb * BLOCK_SIZE + j;
            sum = sum + ACC_WIDTH'(shadow[ADDR_W'(a_addr)]) * ACC_WIDTH'(shadow[ADDR_W'(b_addr)]);
        end
        return sum;
    endfunction

    // ============================================================
    // Compare process
    // ============================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            err_count  = 0;
            elem_count = 0;
            exp_idx    = 0;
            stalled    = 1'b0;
            ack_q      = 1'b0;
            req_q      = 1'b0;
        end else begin
            if (host_we) shadow[host_addr] = host_wdata;
            // Element offered last cycle but not taken must stay put
            if (stalled) begin
                if (!res_valid) begin
                    $display("res_valid dropped while index %0d was stalled", held_index);
                    err_count++;
                end else if (res_data !== held_data) begin
                    $display("FAIL res_data: got %h expected %h while stalled", res_data, held_data);
                    err_count++;
                end else if (res_index !== held_index) begin
                    $display("FAIL res_index: got %h expected %h while stalled",
                             res_index, held_index);
                    err_count++;
                end
            end
            if (res_valid && cmd_ack) begin
                $display("res_valid is high while cmd_ack is high");
                err_count++;
            end
            if (res_valid && res_ready) begin
                if (exp_idx >= TILE_ELEMS) begin
                    $display("Extra result element beyond the %0d of a tile", TILE_ELEMS);
                    err_count++;
                end else begin
                    expected = expected_elem(cmd_row_blk, cmd_col_blk, cmd_k_blk, exp_idx);
                    if (res_index !== IDX_W'(exp_idx)) begin
                        $display("FAIL res_index: got %h expected %h", res_index, IDX_W'(exp_idx));
                        err_count++;
                    end
                    if (res_data !== expected) begin
                        $display("FAIL res_data: got %h expected %h at index %0d",
                                 res_data, expected, exp_idx);
                        err_count++;
                    end
                end
                exp_idx++;
                elem_count++;
            end
            stalled    = res_valid && !res_ready;
            held_data  = res_data;
            held_index = res_index;
            // Four-phase command rules
            if (cmd_ack && !ack_q) begin
                if (exp_idx != TILE_ELEMS) begin
                    $display("cmd_ack rose after %0d of %0d elements", exp_idx, TILE_ELEMS);
                    err_count++;
                end
                exp_idx = 0;
            end
            if (ack_q && !cmd_ack && req_q) begin
                $display("cmd_ack fell while cmd_req was still high");
                err_count++;
            end
            ack_q = cmd_ack;
            req_q = cmd_req;
        end
    end

endmodule

//--- verification/tb_block_mmu.sv
// ============================================================
// Blocked matrix multiply testbench
// Loads A and B, issues tile commands and stalls the result
// stream at random; checker module does the comparing
// ============================================================
`timescale 1ns/1ps

module tb_block_mmu import matrix_pkg::*;;

    localparam int IDX_W   = $clog2(TILE_ELEMS);
    localparam int NUM_BLK = MATRIX_SIZE / BLOCK_SIZE;
    localparam int TIMEOUT = 2000;          // Cycles per wait

    logic                  clk;
    logic                  rst_n;
    logic                  host_we;
    logic [ADDR_W-1:0]     host_addr;
    logic [DATA_WIDTH-1:0] host_wdata;
    logic                  cmd_req;
    logic [BLK_IDX_W-1:0]  cmd_row_blk, cmd_col_blk, cmd_k_blk;
    logic                  cmd_ack;
    logic                  res_valid;
    logic [ACC_WIDTH-1:0]  res_data;
    logic [IDX_W-1:0]      res_index;
    logic                  res_ready;

    int          err_count, elem_count;     // From the checker
    int          tb_errors;
    int          test_num;
    int          errs_before;
    bit          hung;
    bit          ready_random;
    logic [15:0] lfsr_state;

    always #5 clk = ~clk;

    block_mmu_top block_mmu_top_inst (.*);

    block_mmu_checker checker_inst (.*);

    // ============================================================
    // Random source
    // ============================================================
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        int b;
        v = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int total_errors();
        return err_count + tb_errors;
    endfunction

    // ============================================================
    // Stimulus tasks
    // ============================================================
    // Every cycle boundary goes through here, so res_ready follows
    task automatic next_cycle();
        logic [31:0] v;
        @(negedge clk);
        if (ready_random) begin
            v = random_bits(1);
            res_ready = v[0];
        end else begin
            res_ready = 1'b1;
        end
    endtask

    task automatic load_matrices();
        int addr;
        logic [31:0] v;
        for (addr = 0; addr < MEM_DEPTH; addr++) begin
            next_cycle();
            v = random_bits(DATA_WIDTH);
            host_we    = 1'b1;
            host_addr  = ADDR_W'(addr);
            host_wdata = v[DATA_WIDTH-1:0];
        end
        next_cycle();
        host_we = 1'b0;
    endtask

    // Full four-phase command, cmd_req held hold cycles past cmd_ack
    task automatic run_command(int rb, int cb, int kb, int hold);
        int n;
        int first_elem;
        if (hung) return;
        first_elem = elem_count;
        next_cycle();
        cmd_row_blk = BLK_IDX_W'(rb);
        cmd_col_blk = BLK_IDX_W'(cb);
        cmd_k_blk   = BLK_IDX_W'(kb);
        cmd_req     = 1'b1;
        n = 0;
        while (!cmd_ack && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!cmd_ack) begin
            $display("Timeout waiting for cmd_ack, command %0d %0d %0d", rb, cb, kb);
            hung    = 1'b1;
            cmd_req = 1'b0;
            return;
        end
        repeat (hold) next_cycle();
        cmd_req = 1'b0;
        n = 0;
        while (cmd_ack && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (cmd_ack) begin
            $display("Timeout waiting for cmd_ack to fall, command %0d %0d %0d", rb, cb, kb);
            hung = 1'b1;
            return;
        end
        if (elem_count - first_elem != TILE_ELEMS) begin
            $display("Command %0d %0d %0d delivered %0d elements instead of %0d",
                     rb, cb, kb, elem_count - first_elem, TILE_ELEMS);
            tb_errors++;
        end
    endtask

    task automatic report_test(string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, total_errors() - errs_before);
        errs_before = total_errors();
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        cmd_req      = 1'b0;
        cmd_row_blk  = '0;
        cmd_col_blk  = '0;
        cmd_k_blk    = '0;
        res_ready    = 1'b1;
        lfsr_state   = 16'd7;
        tb_errors    = 0;
        test_num     = 0;
        errs_before  = 0;
        hung         = 1'b0;
        ready_random = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        next_cycle();

        if (cmd_ack !== 1'b0) begin
            $display("FAIL cmd_ack: got %h expected %h", cmd_ack, 1'b0);
            tb_errors++;
        end
        if (res_valid !== 1'b0) begin
            $display("FAIL res_valid: got %h expected %h", res_valid, 1'b0);
            tb_errors++;
        end
        load_matrices();
        run_command(0, 0, 0, 0);
        report_test("reset state and first tile");

        ready_random = 1'b1;
        for (int rb = 0; rb < NUM_BLK; rb++) begin
            for (int cb = 0; cb < NUM_BLK; cb++) begin
                for (int kb = 0; kb < NUM_BLK; kb++) begin
                    run_command(rb, cb, kb, 0);
                end
            end
        end
        report_test("all block index combinations");

        run_command(NUM_BLK - 1, NUM_BLK - 1, NUM_BLK - 1, 0);
        run_command(NUM_BLK - 1, 0, 0, 0);
        report_test("random result stalls");

        run_command(1 % NUM_BLK, 0, NUM_BLK - 1, 20);   // Late cmd_req release
        run_command(0, NUM_BLK - 1, 0, 5);
        report_test("four-phase command handshake");

        if (!hung) load_matrices();
        run_command(NUM_BLK - 1, 0, NUM_BLK - 1, 0);
        run_command(0, NUM_BLK - 1, 0, 0);
        report_test("memory rewrite between commands");

        $display("Summary: %0d tests, %0d elements checked, %0d errors",
                 test_num, elem_count, total_errors());
        if (hung || total_errors() != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/matrix_pkg.sv
logic/mem_bus_if.sv
logic/matrix_mem.sv
logic/mem_arbiter.sv
logic/tile_fetcher.sv
logic/tile_multiplier.sv
logic/block_mmu_top.sv
verification/block_mmu_checker.sv
verification/tb_block_mmu.sv
